/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/rvCorePkg.sv
      - design/controlUnit.sv
      - design/immGen.sv
      - design/alu.sv
      - design/regFile.sv
      - design/pcUnit.sv
      - design/rvCore.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/rvCoreTb.sv

/* design/alu.sv */
`include "rvCoreDefs.svh"

module alu import rvCorePkg::*; (
    input  aSrcE             aSrc,
    input  bSrcE             bSrc,
    input  aluOpE            aluOp,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] result,
    output logic             zero,
    output logic             less
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [4:0]       shamt;
    logic             sLess;
    logic             uLess;

    assign a = (aSrc == aPc) ? pc : rs1Data;

    always_comb begin
        case (bSrc)
            bImm:    b = imm;
            bFour:   b = `XLEN'd4;
            default: b = rs2Data;
        endcase
    end

    assign shamt = b[4:0];
    assign sLess = $signed(a) < $signed(b);
    assign uLess = a < b;

    always_comb begin
        case (aluOp)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {{(`XLEN-1){1'b0}}, sLess};
            SLTU:    result = {{(`XLEN-1){1'b0}}, uLess};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // compare flags for the branch decision
    assign zero = (result == '0);
    assign less = (aluOp == SLTU) ? uLess : sLess;

endmodule

/* design/controlUnit.sv */
`include "rvCoreDefs.svh"

module controlUnit import rvCorePkg::*; (
    input  instrT instr,
    input  logic  zero,
    input  logic  less,
    output ctrlT  ctrl,
    output pcSelT pcSel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       altOp;   // funct7[5], SUB / SRA
    logic       isJal;
    logic       isJalr;
    logic       isBranch;
    logic       taken;
    aluOpE      branchOp;

    // OP and OP-IMM share one funct3 table
    function automatic aluOpE arithOp(input logic [2:0] f3, input logic alt,
                                      input logic allowSub);
        aluOpE op;
        case (f3)
            `F3_ADD:  op = (alt && allowSub) ? SUB : ADD;
            `F3_SLL:  op = SLL;
            `F3_SLT:  op = SLT;
            `F3_SLTU: op = SLTU;
            `F3_XOR:  op = XOR;
            `F3_SR:   op = alt ? SRA : SRL;
            `F3_OR:   op = OR;
            `F3_AND:  op = AND;
            default:  op = ADD;
        endcase
        return op;
    endfunction

    assign opcode = instr.rFmt.opcode;
    assign funct3 = instr.rFmt.funct3;
    assign altOp  = instr.rFmt.funct7[5];

    assign isJal    = (opcode == `OP_JAL);
    assign isJalr   = (opcode == `OP_JALR);
    assign isBranch = (opcode == `OP_BRANCH);

    // unsigned compares go through SLTU, the rest through SUB
    assign branchOp = (funct3 == `F3_BLTU || funct3 == `F3_BGEU) ? SLTU : SUB;

    always_comb begin
        case (funct3)
            `F3_BEQ:  taken = zero;
            `F3_BNE:  taken = !zero;
            `F3_BLT:  taken = less;
            `F3_BGE:  taken = !less;
            `F3_BLTU: taken = less;
            `F3_BGEU: taken = !less;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl        = '0;   // unknown opcodes fall through as a no-op
        ctrl.immSel = immI;
        ctrl.aluOp  = ADD;
        ctrl.aSrc   = aReg;
        ctrl.bSrc   = bReg;
        ctrl.wbSrc  = wbAlu;
        case (opcode)
            `OP_LUI: begin
                ctrl.immSel   = immU;
                ctrl.bSrc     = bImm;  // rs1 forced to x0 at the top
                ctrl.regWrite = 1'b1;
            end
            `OP_AUIPC: begin
                ctrl.immSel   = immU;
                ctrl.aSrc     = aPc;
                ctrl.bSrc     = bImm;
                ctrl.regWrite = 1'b1;
            end
            `OP_JAL, `OP_JALR: begin
                ctrl.immSel   = isJal ? immJ : immI;
                ctrl.aSrc     = aPc;   // link value pc + 4
                ctrl.bSrc     = bFour;
                ctrl.regWrite = 1'b1;
            end
            `OP_BRANCH: begin
                ctrl.immSel = immB;
                ctrl.aluOp  = branchOp;
            end
            `OP_LOAD: begin
                ctrl.bSrc     = bImm;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.wbSrc    = wbMem;
            end
            `OP_STORE: begin
                ctrl.immSel   = immS;
                ctrl.bSrc     = bImm;
                ctrl.memWrite = 1'b1;
            end
            `OP_IMM: begin
                ctrl.bSrc     = bImm;
                ctrl.aluOp    = arithOp(funct3, altOp, 1'b0);
                ctrl.regWrite = 1'b1;
            end
            `OP_REG: begin
                ctrl.aluOp    = arithOp(funct3, altOp, 1'b1);
                ctrl.regWrite = 1'b1;
            end
            `OP_SYSTEM: ctrl.isHalt = (funct3 == `F3_PRIV);
            default: ;
        endcase
    end

    assign pcSel.redirect = isJal || isJalr || (isBranch && taken);
    assign pcSel.fromReg  = isJalr;

endmodule

/* design/immGen.sv */
`include "rvCoreDefs.svh"

module immGen import rvCorePkg::*; (
    input  instrT            instr,
    input  immSelE           immSel,
    output logic [`XLEN-1:0] imm
);

    always_comb begin
        case (immSel)
            immI: imm = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
            immS: imm = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
            immB: begin
                // even offset, bit 0 implied
                imm = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12, instr.bFmt.imm11,
                       instr.bFmt.immHi, instr.bFmt.immLo, 1'b0};
            end
            immU: imm = {instr.uFmt.imm, 12'b0};
            immJ: begin
                imm = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20, instr.jFmt.immHi,
                       instr.jFmt.imm11, instr.jFmt.immLo, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

/* design/pcUnit.sv */
`include "rvCoreDefs.svh"

module pcUnit import rvCorePkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  pcSelT            pcSel,
    input  logic             isHalt,
    input  logic [`XLEN-1:0] target,
    output logic [`XLEN-1:0] pc,
    output logic             halted,
    output logic             active
);

    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] redirectPc;
    logic [`XLEN-1:0] nextPc;

    assign seqPc      = pc + `XLEN'd4;
    assign redirectPc = {target[`XLEN-1:1], target[0] & !pcSel.fromReg}; // JALR clears bit 0
    assign nextPc     = pcSel.redirect ? redirectPc : seqPc;

    assign active = !reset && !halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else if (active) begin
            if (isHalt) begin
                halted <= 1'b1;  // pc stays on the halt instruction
            end else begin
                pc <= nextPc;
            end
        end
    end

    // branch and jump offsets must keep the pc on word boundaries
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc misaligned: %h", pc);

endmodule

/* design/regFile.sv */
`include "rvCoreDefs.svh"

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic             writeEnable,
    input  logic [`XLEN-1:0] writeData,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != 5'd0) begin  // x0 drops writes
            regs[rd] <= writeData;
        end
    end

    // x0 always reads zero
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* design/rvCore.sv */
`include "rvCoreDefs.svh"

module rvCore import rvCorePkg::*; (
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] instrAddr,
    input  instrT            instr,
    output dataReqT          dataReq,
    input  logic [`XLEN-1:0] dataRdata,
    output retireT           retire,
    output logic             halted
);

    ctrlT             ctrl;
    pcSelT            pcSel;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] wbData;
    logic [4:0]       rs1Index;
    logic             zero;
    logic             less;
    logic             active;
    logic             regWrite;

    assign instrAddr = pc;

    // U formats carry no rs1 field, read x0 so LUI passes imm through
    assign rs1Index = (ctrl.immSel == immU) ? 5'd0 : instr.rFmt.rs1;

    // the ALU is busy with the compare or the link value, so the target gets its own adder
    assign target = (pcSel.fromReg ? rs1Data : pc) + imm;

    controlUnit uControl (.instr(instr), .zero(zero), .less(less), .ctrl(ctrl), .pcSel(pcSel));

    immGen uImm (.instr(instr), .immSel(ctrl.immSel), .imm(imm));

    alu uAlu (
        .aSrc(ctrl.aSrc), .bSrc(ctrl.bSrc), .aluOp(ctrl.aluOp),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .pc(pc), .imm(imm),
        .result(aluResult), .zero(zero), .less(less)
    );

    regFile uRegs (
        .clk(clk), .reset(reset),
        .rs1(rs1Index), .rs2(instr.rFmt.rs2), .rd(instr.rFmt.rd),
        .writeEnable(regWrite), .writeData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    pcUnit uPc (
        .clk(clk), .reset(reset), .pcSel(pcSel), .isHalt(ctrl.isHalt),
        .target(target), .pc(pc), .halted(halted), .active(active)
    );

    assign wbData   = (ctrl.wbSrc == wbMem) ? dataRdata : aluResult;
    assign regWrite = active && ctrl.regWrite;

    assign dataReq.valid = active && (ctrl.memRead || ctrl.memWrite);
    assign dataReq.write = ctrl.memWrite;
    assign dataReq.addr  = aluResult;
    assign dataReq.wdata = rs2Data;

    // describes the instruction that completes at the next edge
    assign retire.valid   = active;
    assign retire.pc      = pc;
    assign retire.rd      = instr.rFmt.rd;
    assign retire.rdWrite = regWrite && (instr.rFmt.rd != 5'd0);
    assign retire.rdValue = wbData;

    dataAligned: assert property (@(posedge clk) disable iff (reset)
        dataReq.valid |-> dataReq.addr[1:0] == 2'b00)
        else $error("unaligned word access at %h", dataReq.addr);

endmodule

/* design/rvCoreDefs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath sizes
`define XLEN      32
`define REG_COUNT 32
`define RESET_PC  32'h0000_0000

// major opcodes, bits [6:0]
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_SYSTEM 7'b1110011

// funct3 for OP and OP-IMM
`define F3_ADD    3'b000
`define F3_SLL    3'b001
`define F3_SLT    3'b010
`define F3_SLTU   3'b011
`define F3_XOR    3'b100
`define F3_SR     3'b101 // SRL / SRA, split by funct7
`define F3_OR     3'b110
`define F3_AND    3'b111

// funct3 for branches
`define F3_BEQ    3'b000
`define F3_BNE    3'b001
`define F3_BLT    3'b100
`define F3_BGE    3'b101
`define F3_BLTU   3'b110
`define F3_BGEU   3'b111

`define F3_PRIV   3'b000 // ECALL / EBREAK

`endif

/* design/rvCorePkg.sv */
`include "rvCoreDefs.svh"

package rvCorePkg;

    // one instruction word, read per format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;  // imm[11:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;  // imm[4:0]
            logic [6:0] opcode;
        } sFmt;
        struct packed {
            logic       imm12;
            logic [5:0] immHi;  // imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] immLo;  // imm[4:1]
            logic       imm11;
            logic [6:0] opcode;
        } bFmt;
        struct packed {
            logic [19:0] imm;   // imm[31:12]
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uFmt;
        struct packed {
            logic       imm20;
            logic [9:0] immLo;  // imm[10:1]
            logic       imm11;
            logic [7:0] immHi;  // imm[19:12]
            logic [4:0] rd;
            logic [6:0] opcode;
        } jFmt;
    } instrT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSelE;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } aluOpE;

    typedef enum logic       {aReg, aPc} aSrcE;
    typedef enum logic [1:0] {bReg, bImm, bFour} bSrcE;
    typedef enum logic       {wbAlu, wbMem} wbSrcE;

    typedef struct packed {
        immSelE immSel;
        aluOpE  aluOp;
        aSrcE   aSrc;
        bSrcE   bSrc;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        wbSrcE  wbSrc;
        logic   isHalt;
    } ctrlT;

    typedef struct packed {
        logic redirect;  // take the computed target
        logic fromReg;   // JALR, base is rs1
    } pcSelT;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  wdata;
    } dataReqT;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [4:0]        rd;
        logic              rdWrite;
        logic [`XLEN-1:0]  rdValue;
    } retireT;

endpackage

/* sources.f */
+incdir+design
design/rvCorePkg.sv
design/controlUnit.sv
design/immGen.sv
design/alu.sv
design/regFile.sv
design/pcUnit.sv
design/rvCore.sv
verification/rvCoreTb.sv

/* verification/rvCoreTb.sv */
`include "rvCoreDefs.svh"

module rvCoreTb import rvCorePkg::*; ();

    localparam logic [31:0] EBREAK = 32'h0010_0073;
    localparam logic [31:0] NOP    = 32'h0000_0013;  // addi x0, x0, 0

    logic        clk;
    logic        reset;
    logic [31:0] instrAddr;
    instrT       instr;
    dataReqT     dataReq;
    logic [31:0] dataRdata;
    retireT      retire;
    logic        halted;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    retireT      expQ [$];  // expected retire order
    dataReqT     reqQ [$];  // expected data requests
    logic [31:0] progPc;

    rvCore dut0 (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .dataReq(dataReq), .dataRdata(dataRdata), .retire(retire), .halted(halted)
    );

    always #4 clk = ~clk;

    // both memories answer in the same cycle
    assign instr     = imem[instrAddr[9:2]];
    assign dataRdata = dmem[dataReq.addr[9:2]];

    always @(posedge clk) begin
        if (dataReq.valid && dataReq.write) begin
            dmem[dataReq.addr[9:2]] <= dataReq.wdata;
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            abortRun($sformatf("Fail %s: expected %h, got %h", name, exp, got));
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    // RV32I result for OP / OP-IMM, funct3 plus the funct7[5] bit
    function automatic logic [31:0] refOp(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                else return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            `F3_BEQ:  return a == b;
            `F3_BNE:  return a != b;
            `F3_BLT:  return $signed(a) < $signed(b);
            `F3_BGE:  return $signed(a) >= $signed(b);
            `F3_BLTU: return a < b;
            `F3_BGEU: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    // place one word at progPc and expect it to retire
    task automatic emit(input logic [31:0] word, input logic [4:0] rd, input logic wr,
                        input logic [31:0] value);
        retireT e;
        imem[progPc[9:2]] = word;
        e = '{valid: 1'b1, pc: progPc, rd: rd, rdWrite: wr && rd != 5'd0, rdValue: value};
        expQ.push_back(e);
        progPc += 4;
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = encI(12'(i), 5'd0, 3'd0, 5'd0, `OP_IMM);  // nop tagged with its index
            dmem[i] = 32'h9e37_79b9 * (i + 1);
        end
        expQ.delete();
        reqQ.delete();
        progPc = `RESET_PC;
    endtask

    task automatic checkRetire();
        retireT e;
        if (expQ.size() == 0) begin
            abortRun($sformatf("unexpected retire at pc %h", retire.pc));
        end
        e = expQ.pop_front();
        checkHex("retire.pc", retire.pc, e.pc);
        checkHex("instrAddr", instrAddr, e.pc);
        checkHex("retire.rdWrite", retire.rdWrite, e.rdWrite);
        if (e.rdWrite) begin
            checkHex("retire.rd", retire.rd, e.rd);
            checkHex("retire.rdValue", retire.rdValue, e.rdValue);
        end
    endtask

    task automatic checkRequest();
        dataReqT r;
        if (reqQ.size() == 0) begin
            abortRun($sformatf("unexpected data request at %h", dataReq.addr));
        end
        r = reqQ.pop_front();
        checkHex("dataReq.write", dataReq.write, r.write);
        checkHex("dataReq.addr", dataReq.addr, r.addr);
        if (r.write) checkHex("dataReq.wdata", dataReq.wdata, r.wdata);
    endtask

    // reset pulse, run to halt, then watch the halted core
    task automatic runProgram();
        logic done;
        imem[progPc[9:2]] = {7'd0, 5'd0, 5'd0, 3'b010, 5'd0, `OP_STORE};  // past the halt
        @(posedge clk);
        reset <= 1'b1;
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            checkHex("retire.valid", retire.valid, 1'b0);
            checkHex("dataReq.valid", dataReq.valid, 1'b0);
            if (c > 0) begin
                checkHex("halted", halted, 1'b0);  // cleared by the first reset edge
                checkHex("instrAddr", instrAddr, `RESET_PC);
            end
            @(posedge clk);
        end
        reset <= 1'b0;
        done = 1'b0;
        for (int cycles = 0; !done; cycles++) begin
            @(negedge clk);
            if (halted) begin
                done = 1'b1;
            end else begin
                if (retire.valid) checkRetire();
                if (dataReq.valid) checkRequest();
                if (cycles > 300) abortRun("timeout, the core never halted");
            end
        end
        if (expQ.size() != 0) abortRun("core halted before the whole program retired");
        if (reqQ.size() != 0) abortRun("core halted with data requests still missing");
        repeat (10) begin
            @(negedge clk);
            checkHex("halted", halted, 1'b1);
            checkHex("instrAddr", instrAddr, progPc - 4);  // frozen on the halt
            checkHex("retire.valid", retire.valid, 1'b0);
            checkHex("dataReq.valid", dataReq.valid, 1'b0);
        end
    endtask

    task automatic testArith();
        logic [11:0] immA;
        logic [11:0] immB;
        logic [11:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        clearMemories();
        immA = 12'($urandom());
        immB = 12'($urandom());
        a = sext12(immA);
        b = sext12(immB);
        emit(encI(immA, 5'd0, `F3_ADD, 5'd1, `OP_IMM), 5'd1, 1'b1, a);
        emit(encI(immB, 5'd0, `F3_ADD, 5'd2, `OP_IMM), 5'd2, 1'b1, b);
        for (int f = 0; f < 8; f++) begin
            emit(encR(7'h00, 5'd2, 5'd1, 3'(f), 5'd10), 5'd10, 1'b1, refOp(3'(f), 1'b0, a, b));
        end
        emit(encR(7'h20, 5'd2, 5'd1, `F3_ADD, 5'd11), 5'd11, 1'b1, refOp(3'd0, 1'b1, a, b));
        emit(encR(7'h20, 5'd2, 5'd1, `F3_SR, 5'd12), 5'd12, 1'b1, refOp(3'd5, 1'b1, a, b));
        for (int f = 0; f < 8; f++) begin
            imm = (f == 1 || f == 5) ? {7'h00, immB[4:0]} : immB;  // shifts take shamt only
            emit(encI(imm, 5'd1, 3'(f), 5'd13, `OP_IMM), 5'd13, 1'b1,
                 refOp(3'(f), 1'b0, a, sext12(imm)));
        end
        imm = {7'h20, immB[4:0]};  // srai
        emit(encI(imm, 5'd1, `F3_SR, 5'd14, `OP_IMM), 5'd14, 1'b1, refOp(3'd5, 1'b1, a, b));
        emit(encI(12'd5, 5'd1, `F3_ADD, 5'd0, `OP_IMM), 5'd0, 1'b0, 32'd0);
        emit(encR(7'h00, 5'd1, 5'd0, `F3_ADD, 5'd15), 5'd15, 1'b1, a);  // x0 still zero
        emit(EBREAK, 5'd0, 1'b0, 32'd0);
        runProgram();
    endtask

    task automatic testJumps();
        logic [19:0] upA;
        logic [19:0] upB;
        logic [31:0] jalPc;
        logic [31:0] linkJal;
        logic [31:0] linkJalr;
        clearMemories();
        upA = 20'($urandom());
        upB = 20'($urandom());
        emit({upA, 5'd1, `OP_LUI}, 5'd1, 1'b1, {upA, 12'h000});
        emit({upB, 5'd2, `OP_AUIPC}, 5'd2, 1'b1, progPc + {upB, 12'h000});
        jalPc = progPc;
        linkJal = jalPc + 4;
        emit(encJ(21'd16, 5'd3), 5'd3, 1'b1, linkJal);
        progPc = jalPc + 16;
        emit(encI(12'd64, 5'd0, `F3_ADD, 5'd5, `OP_IMM), 5'd5, 1'b1, 32'd64);
        linkJalr = progPc + 4;
        emit(encI(12'd9, 5'd5, 3'b000, 5'd4, `OP_JALR), 5'd4, 1'b1, linkJalr);  // 73, bit 0 dropped
        progPc = 32'd72;
        emit(encR(7'h00, 5'd4, 5'd3, `F3_ADD, 5'd6), 5'd6, 1'b1, linkJal + linkJalr);
        emit(EBREAK, 5'd0, 1'b0, 32'd0);
        runProgram();
    endtask

    task automatic testBranches();
        logic [2:0]  kinds [6];
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        kinds = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
        clearMemories();
        a = sext12({1'b1, 11'($urandom())});  // negative, so signed and unsigned disagree
        b = sext12({1'b0, 11'($urandom())});
        emit(encI(a[11:0], 5'd0, `F3_ADD, 5'd1, `OP_IMM), 5'd1, 1'b1, a);
        emit(encI(b[11:0], 5'd0, `F3_ADD, 5'd2, `OP_IMM), 5'd2, 1'b1, b);
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : 5'd1;
                emit(encB(13'd8, rs2, rs1, kinds[k]), 5'd0, 1'b0, 32'd0);
                if (branchTaken(kinds[k], (rs1 == 1) ? a : b, (rs2 == 1) ? a : b)) begin
                    imem[progPc[9:2]] = NOP;  // skipped
                    progPc += 4;
                end else begin
                    emit(NOP, 5'd0, 1'b0, 32'd0);
                end
            end
        end
        emit(EBREAK, 5'd0, 1'b0, 32'd0);
        runProgram();
    endtask

    task automatic testMemory();
        logic [19:0] hi;
        logic [11:0] lo;
        logic [31:0] word;
        clearMemories();
        hi = 20'($urandom());
        lo = 12'($urandom());
        word = {hi, 12'h000} + sext12(lo);
        // a load sits at the reset pc, so reset must hold its request off
        reqQ.push_back('{valid: 1'b1, write: 1'b0, addr: 32'd72, wdata: 32'd0});
        emit(encI(12'd72, 5'd0, 3'b010, 5'd4, `OP_LOAD), 5'd4, 1'b1, dmem[18]);
        emit(encI(12'd64, 5'd0, `F3_ADD, 5'd1, `OP_IMM), 5'd1, 1'b1, 32'd64);
        emit({hi, 5'd2, `OP_LUI}, 5'd2, 1'b1, {hi, 12'h000});
        emit(encI(lo, 5'd2, `F3_ADD, 5'd2, `OP_IMM), 5'd2, 1'b1, word);
        reqQ.push_back('{valid: 1'b1, write: 1'b1, addr: 32'd72, wdata: word});
        emit({7'd0, 5'd2, 5'd1, 3'b010, 5'd8, `OP_STORE}, 5'd0, 1'b0, 32'd0);  // sw x2, 8(x1)
        reqQ.push_back('{valid: 1'b1, write: 1'b0, addr: 32'd72, wdata: 32'd0});
        emit(encI(12'd8, 5'd1, 3'b010, 5'd3, `OP_LOAD), 5'd3, 1'b1, word);
        emit(EBREAK, 5'd0, 1'b0, 32'd0);
        runProgram();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        void'($urandom(32'hda21));
        testArith();
        testJumps();
        testBranches();
        testMemory();
        $display("sim passed");
        $finish;
    end

endmodule
